//--- pagerank_cluster.f
+incdir+source
source/pagerank_pkg.sv
source/sync_fifo.sv
source/vertex_job_dispatch.sv
source/cu_edge_job_control.sv
source/cu_vertex_pagerank.sv
source/cu_read_arbiter.sv
source/pagerank_cluster.sv
testbench/pagerank_mem_model.sv
testbench/pagerank_cluster_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module pagerank_cluster_tb \
	-f pagerank_cluster.f -o pagerank_sim &&
./obj_dir/pagerank_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }

//--- testbench/pagerank_cluster_tb.sv
`include "pagerank_params.svh"

module pagerank_cluster_tb;

	import pagerank_pkg::*;

	localparam int TOTAL_JOBS      = 62;
	localparam int WATCHDOG_CYCLES = 2000 * TOTAL_JOBS;

	logic           clock;
	logic           rstn;
	vertex_job_t    vertex_in;
	logic           vertex_alfull;
	read_cmd_t      cmd_out;
	logic           cmd_alfull;
	read_resp_t     resp_in;
	vertex_result_t result_out;
	logic [31:0]    vertices_done;
	logic           mem_error;

	integer                seed;
	string                 test_name;
	int                    jobs_sent;
	int                    results_seen;
	int                    cmd_count;
	int                    alfull_cycles;
	int                    vertex_alfull_cycles;
	logic                  alfull_q;
	logic [`RANK_BITS-1:0] expected_sum [int];
	bit                    seen [int];

	pagerank_cluster dut0 (
		.clock        (clock),
		.rstn         (rstn),
		.vertex_in    (vertex_in),
		.vertex_alfull(vertex_alfull),
		.cmd_out      (cmd_out),
		.cmd_alfull   (cmd_alfull),
		.resp_in      (resp_in),
		.result_out   (result_out),
		.vertices_done(vertices_done)
	);

	pagerank_mem_model mem (
		.clock     (clock),
		.rstn      (rstn),
		.cmd_in    (cmd_out),
		.cmd_alfull(cmd_alfull),
		.resp_out  (resp_in),
		.error     (mem_error)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at first error");
	endtask

	// sum over edges of graph data at each edge word
	function automatic logic [`RANK_BITS-1:0] expected_rank_sum(input vertex_job_t job);
		logic [`RANK_BITS-1:0]      acc;
		logic [`VERTEX_ID_BITS-1:0] addr;
		logic [`VERTEX_ID_BITS-1:0] nb;
		acc = '0;
		for (int e = 0; e < int'(job.degree); e++) begin
			addr = job.edge_offset + `VERTEX_ID_BITS'(e);
			nb   = addr * `VERTEX_ID_BITS'(7) + `VERTEX_ID_BITS'(3);
			acc  = acc + (`RANK_BITS'(nb) * `RANK_BITS'(5) + `RANK_BITS'(1));
		end
		return acc;
	endfunction

	task automatic send_job(input vertex_job_t job);
		while (vertex_alfull) begin
			@(posedge clock);
			#1;
		end
		expected_sum[int'(job.vertex_id)] = expected_rank_sum(job);
		jobs_sent++;
		vertex_in       = job;
		vertex_in.valid = 1'b1;
		@(posedge clock);
		#1;
		vertex_in = '0;
	endtask

	task automatic wait_results();
		while (results_seen < jobs_sent) begin
			@(posedge clock);
			#1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// compare process
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin : compare
		int id;
		if (rstn) begin
			assert (!mem_error) else report_failure("memory model saw a bad read address");
			if (result_out.valid) begin
				id = int'(result_out.vertex_id);
				assert (expected_sum.exists(id))
					else report_failure($sformatf("result for vertex %0d that was never sent", id));
				assert (!seen.exists(id))
					else report_failure($sformatf("vertex %0d produced a second result", id));
				assert (result_out.sum == expected_sum[id])
					else report_failure($sformatf("Mismatch %s: vertex %0d expected %h actual %h",
						test_name, id, expected_sum[id], result_out.sum));
				seen[id] = 1'b1;
				results_seen++;
			end
			// pops stop one cycle after cmd_alfull
			assert (!(alfull_q && cmd_out.valid))
				else report_failure("command left the cluster right after cmd_alfull was high");
			if (cmd_out.valid) cmd_count++;
			if (cmd_alfull) alfull_cycles++;
			if (vertex_alfull) vertex_alfull_cycles++;
			alfull_q = cmd_alfull;
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES + 10) @(posedge clock);
		report_failure("timeout: not every result arrived in time");
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	initial begin : stimulus
		vertex_job_t job;
		int          cmds_before;
		seed         = 32'h6731;
		rstn         = 1'b0;
		vertex_in    = '0;
		jobs_sent    = 0;
		results_seen = 0;
		cmd_count    = 0;
		alfull_cycles        = 0;
		vertex_alfull_cycles = 0;
		alfull_q     = 1'b0;
		test_name    = "reset";
		repeat (4) @(posedge clock);
		#1;
		rstn = 1'b1;
		assert (!cmd_out.valid && !result_out.valid)
			else report_failure("output valid bit high after reset");
		assert (vertices_done == 32'd0)
			else report_failure($sformatf("Mismatch %s: vertices_done expected 0 actual %0d",
				test_name, vertices_done));

		test_name = "single_vertex";
		job = '{valid: 1'b1, vertex_id: 16'd1, edge_offset: 16'h0040, degree: 8'd5};
		send_job(job);
		wait_results();

		// no other unit is busy, so no command may appear at all
		test_name   = "degree_zero";
		cmds_before = cmd_count;
		job = '{valid: 1'b1, vertex_id: 16'd2, edge_offset: 16'h1234, degree: 8'd0};
		send_job(job);
		wait_results();
		repeat (20) @(posedge clock);
		#1;
		assert (cmd_count == cmds_before)
			else report_failure("degree-zero vertex issued a read command");

		test_name = "random_jobs";
		for (int k = 0; k < 60; k++) begin
			job.valid       = 1'b1;
			job.vertex_id   = `VERTEX_ID_BITS'(100 + k);
			job.edge_offset = `VERTEX_ID_BITS'($random(seed));
			job.degree      = `DEGREE_BITS'($unsigned($random(seed)) % 21);
			send_job(job);
		end
		wait_results();

		test_name = "count";
		repeat (4) @(posedge clock);
		#1;
		assert (vertices_done == 32'(jobs_sent))
			else report_failure($sformatf("Mismatch %s: vertices_done expected %0d actual %0d",
				test_name, jobs_sent, vertices_done));
		assert (alfull_cycles > 0) else report_failure("cmd_alfull was never raised");
		assert (vertex_alfull_cycles > 0)
			else report_failure("job queue never reached its almost-full level");

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- testbench/pagerank_mem_model.sv
`include "pagerank_params.svh"

module pagerank_mem_model #(
	parameter int SEED = 32'h6731
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  pagerank_pkg::read_cmd_t  cmd_in,
	output logic                     cmd_alfull,
	output pagerank_pkg::read_resp_t resp_out,
	output logic                     error
);

	import pagerank_pkg::*;

	integer     seed;
	int         now;
	int         burst_left;
	read_resp_t pend_resp [$];
	int         pend_due [$];
	// edge words handed to each unit and not yet read back as graph addresses
	int         owed [int];

	function automatic logic [`VERTEX_ID_BITS-1:0] edge_word(input logic [`VERTEX_ID_BITS-1:0] a);
		return `VERTEX_ID_BITS'(32'(a) * 7 + 3);
	endfunction

	function automatic logic [`RANK_BITS-1:0] graph_word(input logic [`VERTEX_ID_BITS-1:0] n);
		return `RANK_BITS'(32'(n) * 5 + 1);
	endfunction

	initial begin
		seed       = SEED;
		now        = 0;
		burst_left = 0;
		cmd_alfull = 1'b0;
		resp_out   = '0;
		error      = 1'b0;
	end

	always @(posedge clock) begin : serve
		int         key;
		int         pick;
		logic       bad_addr;
		read_resp_t r;
		now      = now + 1;
		bad_addr = 1'b0;
		// cmd_in here is the command of the cycle that just ended
		if (rstn && cmd_in.valid) begin
			r       = '0;
			r.valid = 1'b1;
			r.cu_id = cmd_in.cu_id;
			r.kind  = cmd_in.kind;
			if (cmd_in.kind == EDGE_ARRAY_DEST) begin
				r.data    = `RANK_BITS'(edge_word(cmd_in.address));
				key       = int'(cmd_in.cu_id) * (1 << `VERTEX_ID_BITS) +
					int'(edge_word(cmd_in.address));
				owed[key] = owed.exists(key) ? owed[key] + 1 : 1;
			end else begin
				r.data = graph_word(cmd_in.address);
				key    = int'(cmd_in.cu_id) * (1 << `VERTEX_ID_BITS) + int'(cmd_in.address);
				if (owed.exists(key) && owed[key] > 0) begin
					owed[key] = owed[key] - 1;
				end else begin
					$display("memory model: graph read at %h from unit %0d matches no edge word",
						cmd_in.address, cmd_in.cu_id);
					bad_addr = 1'b1;
				end
			end
			pend_resp.push_back(r);
			pend_due.push_back(now + 1 + int'($unsigned($random(seed)) % 8));
		end
		pick = -1;
		foreach (pend_due[i]) begin
			if (pick < 0 && pend_due[i] <= now) begin
				pick = i;
			end
		end
		#1;
		if (bad_addr) begin
			error = 1'b1;
		end
		// at most one answer per cycle with the oldest due going first
		if (pick >= 0) begin
			resp_out = pend_resp[pick];
			pend_resp.delete(pick);
			pend_due.delete(pick);
		end else begin
			resp_out = '0;
		end
		// random back-pressure bursts
		if (burst_left > 0) begin
			burst_left = burst_left - 1;
		end else if (($unsigned($random(seed)) % 10) == 0) begin
			burst_left = 1 + int'($unsigned($random(seed)) % 12);
		end
		cmd_alfull = rstn && (burst_left > 0);
	end

endmodule

//--- source/pagerank_cluster.sv
`include "pagerank_params.svh"

module pagerank_cluster (
	input  logic                         clock,
	input  logic                         rstn,
	input  pagerank_pkg::vertex_job_t    vertex_in,
	output logic                         vertex_alfull,
	output pagerank_pkg::read_cmd_t      cmd_out,
	input  logic                         cmd_alfull,
	input  pagerank_pkg::read_resp_t     resp_in,
	output pagerank_pkg::vertex_result_t result_out,
	output logic [31:0]                  vertices_done
);

	import pagerank_pkg::*;

	logic [`NUM_CU-1:0] cu_idle;
	vertex_job_t        cu_job [`NUM_CU];
	read_cmd_t          cu_cmd [`NUM_CU];
	vertex_result_t     cu_result [`NUM_CU];
	buffer_status_t     cu_cmd_status [`NUM_CU];
	read_resp_t         cu_resp [`NUM_CU];

	vertex_job_dispatch dispatch (
		.clock        (clock),
		.rstn         (rstn),
		.vertex_in    (vertex_in),
		.vertex_alfull(vertex_alfull),
		.cu_idle      (cu_idle),
		.cu_job       (cu_job)
	);

	////////////////////////////////////////////////////////////
	// compute units
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `NUM_CU; i++) begin : g_cu
		cu_vertex_pagerank #(
			.CU_ID(i)
		) cu (
			.clock            (clock),
			.rstn             (rstn),
			.vertex_job       (cu_job[i]),
			.cu_idle          (cu_idle[i]),
			.resp_in          (cu_resp[i]),
			.cmd_buffer_status(cu_cmd_status[i]),
			.cmd_out          (cu_cmd[i]),
			.result_out       (cu_result[i])
		);
	end

	cu_read_arbiter arbiter (
		.clock        (clock),
		.rstn         (rstn),
		.cu_cmd       (cu_cmd),
		.cu_result    (cu_result),
		.cu_cmd_status(cu_cmd_status),
		.cmd_alfull   (cmd_alfull),
		.cmd_out      (cmd_out),
		.resp_in      (resp_in),
		.cu_resp      (cu_resp),
		.result_out   (result_out),
		.vertices_done(vertices_done)
	);

endmodule

//--- source/cu_read_arbiter.sv
`include "pagerank_params.svh"

module cu_read_arbiter (
	input  logic                         clock,
	input  logic                         rstn,
	input  pagerank_pkg::read_cmd_t      cu_cmd [`NUM_CU],
	input  pagerank_pkg::vertex_result_t cu_result [`NUM_CU],
	output pagerank_pkg::buffer_status_t cu_cmd_status [`NUM_CU],
	input  logic                         cmd_alfull,
	output pagerank_pkg::read_cmd_t      cmd_out,
	input  pagerank_pkg::read_resp_t     resp_in,
	output pagerank_pkg::read_resp_t     cu_resp [`NUM_CU],
	output pagerank_pkg::vertex_result_t result_out,
	output logic [31:0]                  vertices_done
);

	import pagerank_pkg::*;

	read_cmd_t              cmd_head [`NUM_CU];
	vertex_result_t         res_head [`NUM_CU];
	buffer_status_t         res_status [`NUM_CU];
	logic [`NUM_CU-1:0]     cmd_ready;
	logic [`NUM_CU-1:0]     res_ready;
	logic [`NUM_CU-1:0]     cmd_pop;
	logic [`NUM_CU-1:0]     res_pop;
	logic [`CU_ID_BITS:0]   cmd_pick;
	logic [`CU_ID_BITS:0]   res_pick;
	logic [`CU_ID_BITS-1:0] cmd_ptr;
	logic [`CU_ID_BITS-1:0] res_ptr;
	logic [`CU_ID_BITS-1:0] cmd_sel;
	logic [`CU_ID_BITS-1:0] res_sel;

	// returns {found, unit} for the first requester at or after ptr
	function automatic logic [`CU_ID_BITS:0] rr_pick(input logic [`NUM_CU-1:0] req,
		input logic [`CU_ID_BITS-1:0] ptr);
		logic [`CU_ID_BITS-1:0] idx;
		logic [`CU_ID_BITS:0]   pick;
		pick = '0;
		for (int k = 0; k < `NUM_CU; k++) begin
			idx = `CU_ID_BITS'((int'(ptr) + k) % `NUM_CU);
			if (!pick[`CU_ID_BITS] && req[idx]) begin
				pick = {1'b1, idx};
			end
		end
		return pick;
	endfunction

	function automatic logic [`CU_ID_BITS-1:0] rr_next(input logic [`CU_ID_BITS-1:0] cu);
		return (cu == `CU_ID_BITS'(`NUM_CU - 1)) ? '0 : cu + 1'b1;
	endfunction

	////////////////////////////////////////////////////////////
	// per unit command and result queues
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `NUM_CU; i++) begin : g_queue
		assign cmd_ready[i] = !cu_cmd_status[i].empty;
		assign res_ready[i] = !res_status[i].empty;
		assign cmd_pop[i]   = !cmd_alfull && cmd_pick[`CU_ID_BITS] &&
			(cmd_pick[`CU_ID_BITS-1:0] == `CU_ID_BITS'(i));
		assign res_pop[i]   = res_pick[`CU_ID_BITS] &&
			(res_pick[`CU_ID_BITS-1:0] == `CU_ID_BITS'(i));

		sync_fifo #(.T(read_cmd_t), .DEPTH(`CU_FIFO_DEPTH)) cmd_fifo (
			.clock(clock), .rstn(rstn), .push(cu_cmd[i].valid), .data_in(cu_cmd[i]),
			.pop(cmd_pop[i]), .data_out(cmd_head[i]), .status(cu_cmd_status[i]));

		sync_fifo #(.T(vertex_result_t), .DEPTH(`CU_FIFO_DEPTH)) res_fifo (
			.clock(clock), .rstn(rstn), .push(cu_result[i].valid), .data_in(cu_result[i]),
			.pop(res_pop[i]), .data_out(res_head[i]), .status(res_status[i]));
	end

	assign cmd_pick = rr_pick(cmd_ready, cmd_ptr);
	assign res_pick = rr_pick(res_ready, res_ptr);

	////////////////////////////////////////////////////////////
	// drain pointers, output mux and response routing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_ptr       <= '0;
			cmd_sel       <= '0;
			res_ptr       <= '0;
			res_sel       <= '0;
			vertices_done <= '0;
		end else begin
			if (|cmd_pop) begin
				cmd_sel <= cmd_pick[`CU_ID_BITS-1:0];
				cmd_ptr <= rr_next(cmd_pick[`CU_ID_BITS-1:0]);
			end
			if (|res_pop) begin
				res_sel       <= res_pick[`CU_ID_BITS-1:0];
				res_ptr       <= rr_next(res_pick[`CU_ID_BITS-1:0]);
				vertices_done <= vertices_done + 1'b1;
			end
		end
	end

	// heads are zero unless popped last cycle
	assign cmd_out    = cmd_head[cmd_sel];
	assign result_out = res_head[res_sel];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < `NUM_CU; i++) begin
				cu_resp[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `NUM_CU; i++) begin
				cu_resp[i] <= (resp_in.valid && resp_in.cu_id == `CU_ID_BITS'(i)) ? resp_in : '0;
			end
		end
	end

endmodule

//--- source/cu_vertex_pagerank.sv
`include "pagerank_params.svh"

module cu_vertex_pagerank #(
	parameter int CU_ID = 0
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  pagerank_pkg::vertex_job_t    vertex_job,
	output logic                         cu_idle,
	input  pagerank_pkg::read_resp_t     resp_in,
	input  pagerank_pkg::buffer_status_t cmd_buffer_status,
	output pagerank_pkg::read_cmd_t      cmd_out,
	output pagerank_pkg::vertex_result_t result_out
);

	import pagerank_pkg::*;

	localparam int OUT_BITS = $clog2(`CU_MAX_OUTSTANDING + 1);

	logic                       busy;
	logic                       start;
	logic [`VERTEX_ID_BITS-1:0] vertex_id_q;
	logic [`DEGREE_BITS-1:0]    degree_q;
	logic [`RANK_BITS-1:0]      sum_q;
	logic [`DEGREE_BITS-1:0]    done_cnt;
	logic [OUT_BITS-1:0]        outstanding;
	logic                       hold;
	logic                       edge_stall;
	logic                       edge_take;
	logic                       nb_push;
	logic                       nb_pop;
	read_resp_t                 nb_head;
	buffer_status_t             nb_status;
	read_cmd_t                  edge_cmd;
	logic [`DEGREE_BITS-1:0]    edges_issued;
	logic                       vertex_done;

	assign start   = vertex_job.valid && !busy;
	assign cu_idle = !busy && !vertex_job.valid;

	cu_edge_job_control #(
		.CU_ID(CU_ID)
	) edge_ctrl (
		.clock       (clock),
		.rstn        (rstn),
		.job         (vertex_job),
		.start       (start),
		.cmd_stall   (edge_stall),
		.edge_cmd    (edge_cmd),
		.edges_issued(edges_issued)
	);

	////////////////////////////////////////////////////////////
	// neighbor ids waiting for their graph read
	////////////////////////////////////////////////////////////

	assign nb_push = resp_in.valid && (resp_in.kind == EDGE_ARRAY_DEST);

	sync_fifo #(
		.T    (read_resp_t),
		.DEPTH(`CU_FIFO_DEPTH)
	) nb_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (nb_push),
		.data_in (resp_in),
		.pop     (nb_pop),
		.data_out(nb_head),
		.status  (nb_status)
	);

	// a read counts as outstanding from the cycle it is committed
	assign hold       = cmd_buffer_status.alfull ||
		(outstanding >= OUT_BITS'(`CU_MAX_OUTSTANDING));
	assign nb_pop     = !nb_status.empty && !hold;
	// edge reads only when no neighbor is queued or in flight to cmd_out
	assign edge_stall = hold || !nb_status.empty || nb_head.valid;
	assign edge_take  = edge_cmd.valid && !edge_stall;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= '0;
		end else begin
			case ({nb_pop || edge_take, resp_in.valid})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_out <= '0;
		end else if (nb_head.valid) begin
			cmd_out <= '{valid: 1'b1, cu_id: `CU_ID_BITS'(CU_ID), kind: GRAPH_DATA,
				address: nb_head.data[`VERTEX_ID_BITS-1:0]};
		end else if (edge_take) begin
			cmd_out <= edge_cmd;
		end else begin
			cmd_out <= '0;
		end
	end

	////////////////////////////////////////////////////////////
	// accumulate and finish
	////////////////////////////////////////////////////////////

	// also covers degree zero on the cycle after start
	assign vertex_done = busy && (done_cnt == degree_q) && (edges_issued == degree_q);

	always_ff @(posedge clock) begin
		if (start) begin
			vertex_id_q <= vertex_job.vertex_id;
			degree_q    <= vertex_job.degree;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy     <= 1'b0;
			sum_q    <= '0;
			done_cnt <= '0;
		end else if (start) begin
			busy     <= 1'b1;
			sum_q    <= '0;
			done_cnt <= '0;
		end else begin
			if (resp_in.valid && resp_in.kind == GRAPH_DATA) begin
				sum_q    <= sum_q + resp_in.data;
				done_cnt <= done_cnt + 1'b1;
			end
			if (vertex_done) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			result_out <= '0;
		end else if (vertex_done) begin
			result_out <= '{valid: 1'b1, vertex_id: vertex_id_q, sum: sum_q};
		end else begin
			result_out <= '0;
		end
	end

endmodule

//--- source/cu_edge_job_control.sv
`include "pagerank_params.svh"

module cu_edge_job_control #(
	parameter int CU_ID = 0
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  pagerank_pkg::vertex_job_t  job,
	input  logic                       start,
	input  logic                       cmd_stall,
	output pagerank_pkg::read_cmd_t    edge_cmd,
	output logic [`DEGREE_BITS-1:0]    edges_issued
);

	import pagerank_pkg::*;

	logic [`VERTEX_ID_BITS-1:0] offset_q;
	logic [`DEGREE_BITS-1:0]    degree_q;
	logic                       edge_take;

	////////////////////////////////////////////////////////////
	// edge read offer for the current index
	////////////////////////////////////////////////////////////

	always_comb begin
		edge_cmd.valid   = (edges_issued != degree_q);
		edge_cmd.cu_id   = `CU_ID_BITS'(CU_ID);
		edge_cmd.kind    = EDGE_ARRAY_DEST;
		edge_cmd.address = offset_q + `VERTEX_ID_BITS'(edges_issued);
	end

	// offer taken unless the unit holds it back
	assign edge_take = edge_cmd.valid && !cmd_stall;

	////////////////////////////////////////////////////////////
	// per vertex index
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			offset_q     <= '0;
			degree_q     <= '0;
			edges_issued <= '0;
		end else if (start) begin
			offset_q     <= job.edge_offset;
			degree_q     <= job.degree;
			edges_issued <= '0;
		end else if (edge_take) begin
			edges_issued <= edges_issued + 1'b1;
		end
	end

endmodule

//--- source/vertex_job_dispatch.sv
`include "pagerank_params.svh"

module vertex_job_dispatch (
	input  logic                      clock,
	input  logic                      rstn,
	input  pagerank_pkg::vertex_job_t vertex_in,
	output logic                      vertex_alfull,
	input  logic [`NUM_CU-1:0]        cu_idle,
	output pagerank_pkg::vertex_job_t cu_job [`NUM_CU]
);

	import pagerank_pkg::*;

	vertex_job_t            job_head;
	buffer_status_t         job_status;
	logic                   job_pop;
	logic                   pick_found;
	logic [`CU_ID_BITS-1:0] pick_cu;
	logic [`CU_ID_BITS-1:0] pick_idx;
	logic [`CU_ID_BITS-1:0] rr_ptr;
	logic [`CU_ID_BITS-1:0] sel_cu;

	sync_fifo #(
		.T    (vertex_job_t),
		.DEPTH(`VERTEX_FIFO_DEPTH)
	) job_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (vertex_in.valid),
		.data_in (vertex_in),
		.pop     (job_pop),
		.data_out(job_head),
		.status  (job_status)
	);

	assign vertex_alfull = job_status.alfull;

	// first idle unit at or after the pointer
	always_comb begin
		pick_found = 1'b0;
		pick_cu    = '0;
		pick_idx   = '0;
		for (int k = 0; k < `NUM_CU; k++) begin
			pick_idx = `CU_ID_BITS'((int'(rr_ptr) + k) % `NUM_CU);
			if (!pick_found && cu_idle[pick_idx]) begin
				pick_found = 1'b1;
				pick_cu    = pick_idx;
			end
		end
	end

	assign job_pop = !job_status.empty && pick_found;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rr_ptr <= '0;
			sel_cu <= '0;
		end else if (job_pop) begin
			sel_cu <= pick_cu;
			rr_ptr <= (pick_cu == `CU_ID_BITS'(`NUM_CU - 1)) ? '0 : pick_cu + 1'b1;
		end
	end

	// popped head lands on the unit chosen at pop time
	always_comb begin
		for (int i = 0; i < `NUM_CU; i++) begin
			cu_job[i] = (job_head.valid && sel_cu == `CU_ID_BITS'(i)) ? job_head : '0;
		end
	end

endmodule

//--- source/sync_fifo.sv
module sync_fifo #(
	parameter type T     = logic,
	parameter int  DEPTH = 16
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         push,
	input  T                             data_in,
	input  logic                         pop,
	output T                             data_out,
	output pagerank_pkg::buffer_status_t status
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	T                    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;
	logic                head_valid;

	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// full pushes and empty pops are dropped
	assign do_push = push && (count != CNT_BITS'(DEPTH));
	assign do_pop  = pop && (count != '0);

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// head register is zero between pops, so a struct valid bit reads as a strobe
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			data_out   <= '0;
			head_valid <= 1'b0;
		end else begin
			data_out   <= do_pop ? mem[rd_ptr] : '0;
			head_valid <= do_pop;
		end
	end

	always_comb begin
		status.full   = (count == CNT_BITS'(DEPTH));
		status.alfull = (int'(count) >= DEPTH - 4);
		status.empty  = (count == '0);
		status.valid  = head_valid;
	end

endmodule

//--- source/pagerank_pkg.sv
`include "pagerank_params.svh"

package pagerank_pkg;

	////////////////////////////////////////////////////////////
	// which array a read command targets
	////////////////////////////////////////////////////////////

	typedef enum logic [0:0] {
		EDGE_ARRAY_DEST = 1'b0,
		GRAPH_DATA      = 1'b1
	} struct_kind_t;

	////////////////////////////////////////////////////////////
	// job, command, response and result lines
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                       valid;
		logic [`VERTEX_ID_BITS-1:0] vertex_id;
		logic [`VERTEX_ID_BITS-1:0] edge_offset;
		logic [`DEGREE_BITS-1:0]    degree;
	} vertex_job_t;

	typedef struct packed {
		logic                       valid;
		logic [`CU_ID_BITS-1:0]     cu_id;
		struct_kind_t               kind;
		logic [`VERTEX_ID_BITS-1:0] address;
	} read_cmd_t;

	// data is a neighbor id for edge reads, a contribution for graph reads
	typedef struct packed {
		logic                   valid;
		logic [`CU_ID_BITS-1:0] cu_id;
		struct_kind_t           kind;
		logic [`RANK_BITS-1:0]  data;
	} read_resp_t;

	typedef struct packed {
		logic                       valid;
		logic [`VERTEX_ID_BITS-1:0] vertex_id;
		logic [`RANK_BITS-1:0]      sum;
	} vertex_result_t;

	// queue levels
	typedef struct packed {
		logic full;
		logic alfull;
		logic empty;
		logic valid;
	} buffer_status_t;

endpackage

//--- source/pagerank_params.svh
`ifndef PAGERANK_PARAMS_SVH
`define PAGERANK_PARAMS_SVH

// cluster size and unit tag width
`define NUM_CU 4
`define CU_ID_BITS 2

// data widths
`define VERTEX_ID_BITS 16
`define DEGREE_BITS 8
`define RANK_BITS 32

// queue depths
`define VERTEX_FIFO_DEPTH 16
`define CU_FIFO_DEPTH 16

// most reads one unit may have unanswered
`define CU_MAX_OUTSTANDING 8

`endif
